//--- source/krtop_pkg.sv
/*
  Shared constants and types for the KR PHY top-level control block.
  Build options are fixed here and not per instance. Timer lengths are in
  clk cycles and assume one management clock for the whole block.
*/
`default_nettype none

package krtop_pkg;

  //**************************************************************************
  // register map
  //**************************************************************************
  localparam logic [7:0] ADDR_KRTOP_BASE   = 8'hA0;  // control, read/write
  localparam logic [7:0] ADDR_KRTOP_STATUS = 8'hA1;  // status, read only

  // build options, two bits each
  localparam logic [1:0] SYNTH_FEC      = 2'd1;  // FEC logic present
  localparam logic [1:0] AN_FEC         = 2'd1;  // bit 0 fec_enable, bit 1 request
  localparam logic [1:0] ERR_INDICATION = 2'd0;  // fec_err_ind reset value

  //**************************************************************************
  // sequencer timers, in clk cycles
  //**************************************************************************
  localparam int         TIMER_W           = 16;
  localparam logic [15:0] AN_TIMEOUT_CYCLES = 16'd64;
  localparam logic [15:0] LT_TIMEOUT_CYCLES = 16'd128;
  localparam logic [15:0] LF_TIMEOUT_CYCLES = 16'd32;

  // FEC block lock
  localparam int FEC_LANES     = 4;
  localparam int FEC_LOCK_GOOD = 8;  // good blocks in a row to lock
  localparam int FEC_LOSS_BAD  = 4;  // bad blocks in a row to unlock
  localparam int FEC_GOOD_W    = $clog2(FEC_LOCK_GOOD);
  localparam int FEC_BAD_W     = $clog2(FEC_LOSS_BAD);

  // control register at ADDR_KRTOP_BASE, msb first
  typedef struct packed {
    logic       force_fec;       // 19
    logic       fec_request;     // 18
    logic       fec_err_ind;     // 17
    logic       fec_enable;      // 16
    logic [8:0] spare;           // 15..7 plain r/w storage
    logic [2:0] force_mode;      // 6..4 1 = train, 2 = data
    logic       fail_lt_if_ber;  // 3
    logic       dis_lf_timer;    // 2
    logic       dis_an_timer;    // 1
    logic       seq_reset;       // 0 self-clearing
  } krtop_ctrl_t;

  // sequencer status towards the register file
  typedef struct packed {
    logic       link_rdy;     // live level
    logic       an_timeout;   // one-cycle pulse
    logic       lt_timeout;   // one-cycle pulse
    logic [5:0] pcs_mode_rc;  // one-hot: an, train, data, data+fec
  } seq_status_t;

  // per-lane FEC block strobe
  typedef struct packed {
    logic valid;  // block boundary this cycle
    logic good;   // block decoded clean
  } fec_blk_t;

endpackage

`default_nettype wire

//--- source/bit_resync.sv
/*
  Two-flop synchroniser. Each bit is resynchronised on its own, so only
  slow levels or pulses held over two clk cycles of the far side survive.
*/
`timescale 1ns/1ns
`default_nettype none

module bit_resync #(
  parameter int WIDTH = 2
) (
  input  wire              clk,
  input  wire              reset,
  input  wire [WIDTH-1:0]  d,
  output logic [WIDTH-1:0] q
);

  logic [WIDTH-1:0] meta;  // first stage, may go metastable

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      meta <= '0;
      q    <= '0;
    end else begin
      meta <= d;
      q    <= meta;  // second stage, safe to use
    end
  end

endmodule

`default_nettype wire

//--- source/krtop_csr.sv
/*
  Register file for the KR top level, two words at 0xA0 and 0xA1.
  read and write are single-cycle strobes with no wait state. readdata is
  registered and follows address every cycle. Reading status clears the
  latched timeout bits.
*/
`timescale 1ns/1ns
`default_nettype none

module krtop_csr (
  input  wire                        clk,
  input  wire                        reset,
  // management bus
  input  wire [7:0]                  address,
  input  wire                        read,
  input  wire                        write,
  input  wire [31:0]                 writedata,
  output logic [31:0]                readdata,
  // status in
  input  wire krtop_pkg::seq_status_t seq_status,
  input  wire [3:0]                  fec_block_lock,
  // control out
  output krtop_pkg::krtop_ctrl_t     ctrl
);

  //**************************************************************************
  // timeout resync and latch-high
  //**************************************************************************
  logic an_timeout_sync;  // an_timeout after two flops
  logic lt_timeout_sync;  // lt_timeout after two flops
  logic an_timeout_lh;    // held until status is read
  logic lt_timeout_lh;
  logic clr_status_lh;    // status read this cycle

  // in the full PHY these pulses come from the transceiver clock
  bit_resync #(
    .WIDTH (2)
  ) u_resync_status (
    .clk   (clk),
    .reset (reset),
    .d     ({seq_status.an_timeout, seq_status.lt_timeout}),
    .q     ({an_timeout_sync, lt_timeout_sync})
  );

  assign clr_status_lh = read && (address == krtop_pkg::ADDR_KRTOP_STATUS);

  // set wins over clear, so a pulse landing on the read is not lost
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      an_timeout_lh <= 1'b0;
      lt_timeout_lh <= 1'b0;
    end else begin
      an_timeout_lh <= an_timeout_sync |             // set
                       (an_timeout_lh & ~clr_status_lh);  // hold
      lt_timeout_lh <= lt_timeout_sync |
                       (lt_timeout_lh & ~clr_status_lh);
    end
  end

  //**************************************************************************
  // control register with self-clearing seq_reset
  //**************************************************************************
  logic [1:0] sc_shift;  // bit 0 set means clear seq_reset this edge

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl                <= '0;
      ctrl.dis_an_timer   <= 1'b1;  // AN timer off out of reset
      ctrl.fec_enable     <= krtop_pkg::AN_FEC[0];
      ctrl.fec_request    <= krtop_pkg::AN_FEC[1];
      ctrl.fec_err_ind    <= krtop_pkg::ERR_INDICATION[0];
      sc_shift            <= 2'b00;
    end else begin
      sc_shift <= {1'b0, sc_shift[1]};
      if (sc_shift[0]) begin
        ctrl.seq_reset <= 1'b0;  // two cycles high, now drop
      end
      // a write in the same cycle takes priority over the self-clear
      if (write && (address == krtop_pkg::ADDR_KRTOP_BASE)) begin
        ctrl     <= krtop_pkg::krtop_ctrl_t'(writedata[19:0]);
        sc_shift <= {writedata[0], 1'b0};
      end
    end
  end

  //**************************************************************************
  // registered read mux
  //**************************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      readdata <= '0;
    end else begin
      readdata <= '0;  // unmapped addresses read zero
      case (address)
        krtop_pkg::ADDR_KRTOP_BASE: begin
          readdata[19:0] <= ctrl;
        end
        krtop_pkg::ADDR_KRTOP_STATUS: begin
          readdata[0]     <= seq_status.link_rdy;  // live, not latched
          readdata[1]     <= an_timeout_lh;
          readdata[2]     <= lt_timeout_lh;
          readdata[13:8]  <= seq_status.pcs_mode_rc;
          readdata[16]    <= krtop_pkg::SYNTH_FEC[0];  // FEC ability
          // error indication ability goes with FEC synthesis
          readdata[17]    <= krtop_pkg::SYNTH_FEC[0];
          readdata[23:20] <= fec_block_lock;
        end
        default: begin
          readdata <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/link_sequencer.sv
/*
  Link sequencer: auto-negotiation, link training, then data mode.
  The AN and training protocols are outside; only their done strobes
  arrive here. One phase timer is shared by AN and training.
*/
`timescale 1ns/1ns
`default_nettype none

module link_sequencer (
  input  wire                         clk,
  input  wire                         reset,
  input  wire krtop_pkg::krtop_ctrl_t ctrl,
  input  wire                         an_good,        // AN complete strobe
  input  wire                         lt_good,        // training complete strobe
  input  wire                         ber_high,
  input  wire                         rx_block_lock,
  output krtop_pkg::seq_status_t      seq_status
);

  typedef enum logic [1:0] {
    ST_AN    = 2'd0,
    ST_TRAIN = 2'd1,
    ST_DATA  = 2'd2
  } seq_state_t;

  seq_state_t                    state, state_nxt;
  logic [krtop_pkg::TIMER_W-1:0] phase_tmr, phase_tmr_nxt;  // AN / LT timeout
  logic [krtop_pkg::TIMER_W-1:0] lf_cnt, lf_cnt_nxt;        // link-fail count
  logic                          an_to_nxt, lt_to_nxt;
  logic [5:0]                    pcs_mode_q;
  seq_state_t                    start_state;

  // one-hot mode code for the status word
  function automatic logic [5:0] mode_onehot(input seq_state_t st, input logic fec_on);
    case (st)
      ST_AN:    return 6'b00_0001;
      ST_TRAIN: return 6'b00_0010;
      ST_DATA:  return fec_on ? 6'b00_1000 : 6'b00_0100;
      default:  return 6'b00_0000;
    endcase
  endfunction

  // force_mode picks the entry point, anything unknown means AN
  always_comb begin
    case (ctrl.force_mode)
      3'd1:    start_state = ST_TRAIN;
      3'd2:    start_state = ST_DATA;
      default: start_state = ST_AN;
    endcase
  end

  //**************************************************************************
  // next state
  //**************************************************************************
  always_comb begin
    state_nxt     = state;
    phase_tmr_nxt = phase_tmr + 1'b1;
    lf_cnt_nxt    = '0;
    an_to_nxt     = 1'b0;
    lt_to_nxt     = 1'b0;
    if (ctrl.seq_reset) begin
      state_nxt     = start_state;  // held here while seq_reset is high
      phase_tmr_nxt = '0;
    end else begin
      case (state)
        ST_AN: begin
          if (an_good) begin
            state_nxt     = ST_TRAIN;
            phase_tmr_nxt = '0;
          end else if (ctrl.dis_an_timer) begin
            phase_tmr_nxt = '0;
          end else if (phase_tmr == krtop_pkg::AN_TIMEOUT_CYCLES - 1'b1) begin
            an_to_nxt     = 1'b1;  // pulse and keep negotiating
            phase_tmr_nxt = '0;
          end
        end
        ST_TRAIN: begin
          if (lt_good && !(ber_high && ctrl.fail_lt_if_ber)) begin
            state_nxt     = ST_DATA;
            phase_tmr_nxt = '0;
          end else if (lt_good || (phase_tmr == krtop_pkg::LT_TIMEOUT_CYCLES - 1'b1)) begin
            lt_to_nxt     = 1'b1;  // BER failure or timeout
            state_nxt     = ST_AN;
            phase_tmr_nxt = '0;
          end
        end
        ST_DATA: begin
          phase_tmr_nxt = '0;  // phase timer idle in data
          if (!rx_block_lock && !ctrl.dis_lf_timer) begin
            if (lf_cnt == krtop_pkg::LF_TIMEOUT_CYCLES - 1'b1) begin
              state_nxt = ST_AN;  // link lost, renegotiate
            end else begin
              lf_cnt_nxt = lf_cnt + 1'b1;
            end
          end
        end
        default: begin
          state_nxt     = ST_AN;
          phase_tmr_nxt = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state                 <= ST_AN;
      phase_tmr             <= '0;
      lf_cnt                <= '0;
      seq_status.an_timeout <= 1'b0;
      seq_status.lt_timeout <= 1'b0;
      pcs_mode_q            <= '0;  // no mode shown while in reset
    end else begin
      state                 <= state_nxt;
      phase_tmr             <= phase_tmr_nxt;
      lf_cnt                <= lf_cnt_nxt;
      seq_status.an_timeout <= an_to_nxt;
      seq_status.lt_timeout <= lt_to_nxt;
      pcs_mode_q            <= mode_onehot(state_nxt, ctrl.fec_enable);
    end
  end

  assign seq_status.pcs_mode_rc = pcs_mode_q;
  assign seq_status.link_rdy    = (state == ST_DATA) && rx_block_lock;

endmodule

`default_nettype wire

//--- source/fec_lock_monitor.sv
/*
  FEC block lock per lane, from good/bad strobes at block boundaries.
  No decoding here. Lanes are independent; fec_enable low clears them all.
*/
`timescale 1ns/1ns
`default_nettype none

module fec_lock_monitor (
  input  wire                                               clk,
  input  wire                                               reset,
  input  wire                                               fec_enable,
  input  wire krtop_pkg::fec_blk_t [krtop_pkg::FEC_LANES-1:0] fec_blk,
  output logic [krtop_pkg::FEC_LANES-1:0]                   block_lock
);

  for (genvar ln = 0; ln < krtop_pkg::FEC_LANES; ln++) begin : g_lane
    logic [krtop_pkg::FEC_GOOD_W-1:0] good_cnt;  // good blocks in a row
    logic [krtop_pkg::FEC_BAD_W-1:0]  bad_cnt;   // bad blocks in a row

    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        good_cnt       <= '0;
        bad_cnt        <= '0;
        block_lock[ln] <= 1'b0;
      end else if (!fec_enable) begin
        good_cnt       <= '0;
        bad_cnt        <= '0;
        block_lock[ln] <= 1'b0;
      end else if (fec_blk[ln].valid) begin
        if (fec_blk[ln].good) begin
          bad_cnt <= '0;  // any good block breaks a bad run
          if (!block_lock[ln]) begin
            if (good_cnt == krtop_pkg::FEC_GOOD_W'(krtop_pkg::FEC_LOCK_GOOD - 1)) begin
              block_lock[ln] <= 1'b1;
              good_cnt       <= '0;
            end else begin
              good_cnt <= good_cnt + 1'b1;
            end
          end
        end else begin
          good_cnt <= '0;
          if (block_lock[ln]) begin
            if (bad_cnt == krtop_pkg::FEC_BAD_W'(krtop_pkg::FEC_LOSS_BAD - 1)) begin
              block_lock[ln] <= 1'b0;  // lock lost, start hunting again
              bad_cnt        <= '0;
            end else begin
              bad_cnt <= bad_cnt + 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/krtop.sv
/*
  KR PHY top-level control: register file, link sequencer, FEC lock monitor.
  Single clock domain; the PCS and transceiver datapath are not included.
*/
`timescale 1ns/1ns
`default_nettype none

module krtop (
  input  wire                                               clk,
  input  wire                                               reset,
  // management bus
  input  wire [7:0]                                         address,
  input  wire                                               read,
  input  wire                                               write,
  input  wire [31:0]                                        writedata,
  output logic [31:0]                                       readdata,
  // AN / training results
  input  wire                                               an_good,
  input  wire                                               lt_good,
  input  wire                                               ber_high,
  input  wire                                               rx_block_lock,
  input  wire krtop_pkg::fec_blk_t [krtop_pkg::FEC_LANES-1:0] fec_blk,
  // to the PCS
  output logic                                              link_rdy,
  output logic [5:0]                                        pcs_mode_rc,
  output logic                                              fec_enable,
  output logic                                              fec_request,
  output logic                                              fec_err_ind,
  output logic                                              force_fec
);

  krtop_pkg::krtop_ctrl_t            ctrl;
  krtop_pkg::seq_status_t            seq_status;
  logic [krtop_pkg::FEC_LANES-1:0]   fec_block_lock;

  krtop_csr u_csr (
    .clk            (clk),
    .reset          (reset),
    .address        (address),
    .read           (read),
    .write          (write),
    .writedata      (writedata),
    .readdata       (readdata),
    .seq_status     (seq_status),
    .fec_block_lock (fec_block_lock),
    .ctrl           (ctrl)
  );

  link_sequencer u_seq (
    .clk           (clk),
    .reset         (reset),
    .ctrl          (ctrl),
    .an_good       (an_good),
    .lt_good       (lt_good),
    .ber_high      (ber_high),
    .rx_block_lock (rx_block_lock),
    .seq_status    (seq_status)
  );

  fec_lock_monitor u_fec_mon (
    .clk        (clk),
    .reset      (reset),
    .fec_enable (ctrl.fec_enable),
    .fec_blk    (fec_blk),
    .block_lock (fec_block_lock)
  );

  // control fields out to the PCS
  assign link_rdy    = seq_status.link_rdy;
  assign pcs_mode_rc = seq_status.pcs_mode_rc;
  assign fec_enable  = ctrl.fec_enable;
  assign fec_request = ctrl.fec_request;
  assign fec_err_ind = ctrl.fec_err_ind;
  assign force_fec   = ctrl.force_fec;

endmodule

`default_nettype wire

//--- verif/krtop_tb.sv
/*
  Directed testbench for krtop. Inputs change on the falling clk edge.
  readdata is sampled one cycle after the address is driven. Timer lengths
  and FEC thresholds are taken from krtop_pkg.
*/
`timescale 1ns/1ns
`default_nettype none

module krtop_tb;

  localparam logic [5:0] MODE_AN    = 6'h01;
  localparam logic [5:0] MODE_TRAIN = 6'h02;
  localparam logic [5:0] MODE_DATA  = 6'h04;
  localparam logic [5:0] MODE_DFEC  = 6'h08;  // data with FEC
  // reset, bus traffic and every timer several times over
  localparam int RUN_BUDGET = 16 + 1500 + 10 * (krtop_pkg::AN_TIMEOUT_CYCLES +
    krtop_pkg::LT_TIMEOUT_CYCLES + krtop_pkg::LF_TIMEOUT_CYCLES + 3 * krtop_pkg::FEC_LOCK_GOOD);

  logic        clk;
  logic        reset;
  logic [7:0]  address;
  logic        read;
  logic        write;
  logic [31:0] writedata;
  logic [31:0] readdata;
  logic        an_good;
  logic        lt_good;
  logic        ber_high;
  logic        rx_block_lock;
  krtop_pkg::fec_blk_t [krtop_pkg::FEC_LANES-1:0] fec_blk;
  logic        link_rdy;
  logic [5:0]  pcs_mode_rc;
  logic        fec_enable;
  logic        fec_request;
  logic        fec_err_ind;
  logic        force_fec;

  int     errors;
  int     checks;
  int     tests;
  integer seed;
  int     model_good [krtop_pkg::FEC_LANES];  // good run per lane in the lane model
  int     model_bad  [krtop_pkg::FEC_LANES];
  logic [krtop_pkg::FEC_LANES-1:0] model_lock;

  krtop UUT (
    .clk (clk), .reset (reset),
    .address (address), .read (read), .write (write),
    .writedata (writedata), .readdata (readdata),
    .an_good (an_good), .lt_good (lt_good), .ber_high (ber_high),
    .rx_block_lock (rx_block_lock), .fec_blk (fec_blk),
    .link_rdy (link_rdy), .pcs_mode_rc (pcs_mode_rc),
    .fec_enable (fec_enable), .fec_request (fec_request),
    .fec_err_ind (fec_err_ind), .force_fec (force_fec)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // watchdog
  initial begin
    repeat (RUN_BUDGET) @(posedge clk);
    $display("watchdog: run still going after %0d cycles", RUN_BUDGET);
    $display("CHECKS FAILED");
    $finish;
  end

  //**************************************************************************
  // bus and check helpers start and end on a falling edge
  //**************************************************************************
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    address   = addr;
    writedata = data;
    write     = 1'b1;
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    address = addr;
    read    = 1'b1;
    @(negedge clk);
    read = 1'b0;
    data = readdata;  // registered on the edge just passed
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] d;
    bus_read(addr, d);
    check_word(name, d, exp);
  endtask

  // status word built from link, latched AN/LT timeouts, mode, FEC ability and lock
  function automatic logic [31:0] status_word(input logic link, input logic an_lh,
      input logic lt_lh, input logic [5:0] mode, input logic [3:0] lock);
    logic [31:0] w;
    w        = '0;
    w[0]     = link;
    w[1]     = an_lh;
    w[2]     = lt_lh;
    w[13:8]  = mode;
    w[16]    = krtop_pkg::SYNTH_FEC[0];
    w[17]    = krtop_pkg::SYNTH_FEC[0];
    w[23:20] = lock;
    return w;
  endfunction

  // write control with seq_reset set and let it self-clear
  task automatic restart_seq(input krtop_pkg::krtop_ctrl_t c);
    c.seq_reset = 1'b1;
    bus_write(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c});
    repeat (3) @(negedge clk);
  endtask

  task automatic wait_for_mode(input logic [5:0] exp, input int budget, output int cycles);
    cycles = 0;
    while (pcs_mode_rc !== exp && cycles < budget) begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (pcs_mode_rc === exp) else begin
      $display("pcs_mode_rc did not reach 0x%h within %0d cycles", exp, budget);
      errors++;
    end
  endtask

  task automatic pulse_an_good();
    an_good = 1'b1;
    @(negedge clk);
    an_good = 1'b0;
  endtask

  task automatic pulse_lt_good();
    lt_good = 1'b1;
    @(negedge clk);
    lt_good = 1'b0;
  endtask

  // lane model locks after a good run and unlocks after a bad run while locked
  task automatic model_block(input int ln, input logic v, input logic g);
    if (v && g) begin
      model_bad[ln] = 0;
      if (!model_lock[ln]) model_good[ln] = model_good[ln] + 1;
      if (model_good[ln] >= krtop_pkg::FEC_LOCK_GOOD) begin
        model_lock[ln] = 1'b1;
        model_good[ln] = 0;
      end
    end else if (v) begin
      model_good[ln] = 0;
      if (model_lock[ln]) model_bad[ln] = model_bad[ln] + 1;
      if (model_bad[ln] >= krtop_pkg::FEC_LOSS_BAD) begin
        model_lock[ln] = 1'b0;
        model_bad[ln]  = 0;
      end
    end
  endtask

  task automatic drive_blocks(input logic [3:0] v, input logic [3:0] g);
    for (int ln = 0; ln < krtop_pkg::FEC_LANES; ln++) begin
      fec_blk[ln].valid = v[ln];
      fec_blk[ln].good  = g[ln];
      model_block(ln, v[ln], g[ln]);
    end
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - err0);
  endtask

  //**************************************************************************
  // directed tests
  //**************************************************************************
  task automatic test_reset_values();
    krtop_pkg::krtop_ctrl_t c;
    int err0;
    err0          = errors;
    c             = '0;
    c.dis_an_timer = 1'b1;
    c.fec_enable  = krtop_pkg::AN_FEC[0];
    c.fec_request = krtop_pkg::AN_FEC[1];
    read_expect(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c}, "control");
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_AN, 4'h0),
                "status");
    check_word("fec_enable", 32'(fec_enable), 32'(c.fec_enable));
    check_word("fec_request", 32'(fec_request), 32'(c.fec_request));
    report_test("reset values", err0);
  endtask

  task automatic test_write_readback();
    krtop_pkg::krtop_ctrl_t c;
    int err0;
    err0             = errors;
    c                = '0;
    c.spare          = 9'h1a5;
    c.fail_lt_if_ber = 1'b1;
    c.dis_lf_timer   = 1'b1;  // keeps DATA once forced there
    c.dis_an_timer   = 1'b1;
    c.fec_enable     = 1'b1;
    c.fec_err_ind    = 1'b1;
    c.force_fec      = 1'b1;
    bus_write(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c});
    read_expect(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c}, "control");
    check_word("fec_err_ind", 32'(fec_err_ind), 32'h1);
    check_word("force_fec", 32'(force_fec), 32'h1);
    check_word("fec_request", 32'(fec_request), 32'h0);
    // seq_reset with force_mode 2 and FEC off so DATA shows plain
    c.force_mode = 3'd2;
    c.fec_enable = 1'b0;
    c.seq_reset  = 1'b1;
    bus_write(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c});
    read_expect(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c}, "control after seq_reset");
    @(negedge clk);
    c.seq_reset = 1'b0;  // cleared by the third cycle after the write
    read_expect(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c}, "control self-cleared");
    check_word("pcs_mode_rc", 32'(pcs_mode_rc), 32'(MODE_DATA));
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_DATA, 4'h0),
                "status");
    report_test("register write/readback", err0);
  endtask

  task automatic test_an_timeout();
    krtop_pkg::krtop_ctrl_t c;
    int err0;
    err0         = errors;
    c            = '0;
    c.fec_enable = 1'b1;
    restart_seq(c);  // AN timer running
    repeat (krtop_pkg::AN_TIMEOUT_CYCLES + 3 + 8) @(negedge clk);
    c.dis_an_timer = 1'b1;
    bus_write(krtop_pkg::ADDR_KRTOP_BASE, {12'h0, c});
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b1, 1'b0, MODE_AN, 4'h0),
                "status latched");
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_AN, 4'h0),
                "status cleared");
    report_test("AN timeout latch", err0);
  endtask

  task automatic test_link_up_fail();
    krtop_pkg::krtop_ctrl_t c;
    int err0;
    int n;
    err0           = errors;
    c              = '0;
    c.dis_an_timer = 1'b1;
    c.fec_enable   = 1'b1;
    restart_seq(c);
    wait_for_mode(MODE_AN, 4, n);
    pulse_an_good();
    wait_for_mode(MODE_TRAIN, 4, n);
    pulse_lt_good();
    wait_for_mode(MODE_DFEC, 4, n);
    rx_block_lock = 1'b1;
    @(negedge clk);
    check_word("link_rdy", 32'(link_rdy), 32'h1);
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b1, 1'b0, 1'b0, MODE_DFEC, 4'h0),
                "status link up");
    rx_block_lock = 1'b0;
    wait_for_mode(MODE_AN, krtop_pkg::LF_TIMEOUT_CYCLES + 8, n);
    checks++;
    assert (n >= int'(krtop_pkg::LF_TIMEOUT_CYCLES)) else begin
      $display("link dropped after %0d cycles, before the link-fail timeout", n);
      errors++;
    end
    check_word("link_rdy", 32'(link_rdy), 32'h0);
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_AN, 4'h0),
                "status link down");
    report_test("link-up and link fail", err0);
  endtask

  task automatic test_ber_fail();
    krtop_pkg::krtop_ctrl_t c;
    int err0;
    int n;
    err0             = errors;
    c                = '0;
    c.dis_an_timer   = 1'b1;
    c.fail_lt_if_ber = 1'b1;
    c.fec_enable     = 1'b1;
    restart_seq(c);
    pulse_an_good();
    wait_for_mode(MODE_TRAIN, 4, n);
    ber_high = 1'b1;
    pulse_lt_good();
    wait_for_mode(MODE_AN, 4, n);
    repeat (3) @(negedge clk);  // resync plus latch
    ber_high = 1'b0;
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b1, MODE_AN, 4'h0),
                "status LT timeout");
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_AN, 4'h0),
                "status cleared");
    report_test("training failure on BER", err0);
  endtask

  task automatic test_fec_lock();
    int   err0;
    logic g1;
    err0       = errors;
    model_lock = '0;
    for (int ln = 0; ln < krtop_pkg::FEC_LANES; ln++) begin
      model_good[ln] = 0;
      model_bad[ln]  = 0;
    end
    // lanes 0 and 2 clean, lane 1 mostly good, lane 3 idle
    for (int i = 0; i < 3 * krtop_pkg::FEC_LOCK_GOOD; i++) begin
      g1 = (($random(seed) & 7) != 0);
      drive_blocks(4'b0111, {1'b0, 1'b1, g1, 1'b1});
    end
    drive_blocks(4'b0000, 4'b0000);
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS, status_word(1'b0, 1'b0, 1'b0, MODE_AN, model_lock),
                "status lock");
    repeat (krtop_pkg::FEC_LOSS_BAD) drive_blocks(4'b0001, 4'b0000);
    drive_blocks(4'b0000, 4'b0000);
    // lane 0 unlocked and the other lanes unchanged
    read_expect(krtop_pkg::ADDR_KRTOP_STATUS,
                status_word(1'b0, 1'b0, 1'b0, MODE_AN, {model_lock[3:1], 1'b0}),
                "status lane 0 lost");
    report_test("FEC lock", err0);
  endtask

  initial begin
    seed          = 32'ha4051284;
    reset         = 1'b1;
    address       = '0;
    read          = 1'b0;
    write         = 1'b0;
    writedata     = '0;
    an_good       = 1'b0;
    lt_good       = 1'b0;
    ber_high      = 1'b0;
    rx_block_lock = 1'b0;
    fec_blk       = '0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    model_lock    = '0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    test_reset_values();
    test_write_readback();
    test_an_timeout();
    test_link_up_fail();
    test_ber_fail();
    test_fec_lock();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/krtop_pkg.sv
source/bit_resync.sv
source/krtop_csr.sv
source/link_sequencer.sv
source/fec_lock_monitor.sv
source/krtop.sv
verif/krtop_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the krtop testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module krtop_tb \
  -o krtop_tb_sim

./obj_dir/krtop_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation: pass"
  exit 0
else
  echo "simulation: fail, see sim.log"
  exit 1
fi
